/* rtl/tc_cfg.svh */
/*
 * Traffic cop configuration macros
 * Bus widths, port counts and the address prefixes of both channels
 */

`ifndef TC_CFG_SVH
`define TC_CFG_SVH

// Wishbone bus widths
`define TC_AW 32
`define TC_DW 32
`define TC_SW 4

// Port counts
`define TC_NUM_INIT 4
`define TC_NUM_SHARED 4

// Target 0 owns the top address nibble 0x8
`define TC_T0_PREFIX_W 4
`define TC_T0_PREFIX 4'h8

// Shared channel covers top bits 00, the next two bits pick target 1 to 4
`define TC_SHD_PREFIX_W 2
`define TC_SHD_PREFIX 2'b00
`define TC_SHD_SEL_LSB 28

`endif

/* rtl/tc_pkg.sv */
/*
 * Traffic cop package
 * Bus vector types, request and response structs, arbiter state enum
 */

`default_nettype none

`include "tc_cfg.svh"

package tc_pkg;

	// Bus vectors
	typedef logic [`TC_AW-1:0] tc_addr_t;
	typedef logic [`TC_DW-1:0] tc_data_t;
	typedef logic [`TC_SW-1:0] tc_sel_t;

	// Index of one initiator port
	typedef logic [$clog2(`TC_NUM_INIT)-1:0] tc_init_idx_t;

	// Initiator to target direction of one Wishbone link
	typedef struct packed {
		logic     cyc;
		logic     stb;
		tc_addr_t adr;
		tc_sel_t  sel;
		logic     we;
		tc_data_t dat;
	} tc_req_t;

	// Target to initiator direction
	typedef struct packed {
		tc_data_t dat;
		logic     ack;
		logic     err;
	} tc_rsp_t;

	// Channel ownership
	typedef enum logic {
		ARB_IDLE,
		ARB_OWNED
	} tc_arb_state_e;

endpackage

`default_nettype wire

/* rtl/tc_arbiter.sv */
/*
 * Channel arbiter
 * Grants one channel to the lowest requesting initiator and holds the
 * grant until the owner stops requesting
 */

`timescale 1ns/10ps
`default_nettype none

`include "tc_cfg.svh"

module tc_arbiter import tc_pkg::*; (
	input  logic                    wb_clk_i,
	input  logic                    rst_n_i,
	input  logic [`TC_NUM_INIT-1:0] req_i,
	output logic                    owned_o,
	output tc_init_idx_t            owner_o
);

	tc_arb_state_e state_q;
	tc_arb_state_e state_d;
	tc_init_idx_t  owner_q;
	tc_init_idx_t  owner_d;

	// Fixed priority pick, initiator 0 first
	function automatic tc_init_idx_t lowest_req(input logic [`TC_NUM_INIT-1:0] req);
		tc_init_idx_t idx;
		idx = '0;
		for (int i = `TC_NUM_INIT - 1; i >= 0; i--) begin
			if (req[i]) begin
				idx = tc_init_idx_t'(i);
			end
		end
		return idx;
	endfunction

	always_comb begin
		state_d = state_q;
		owner_d = owner_q;
		case (state_q)
			ARB_IDLE: begin
				if (|req_i) begin
					state_d = ARB_OWNED;
					owner_d = lowest_req(req_i);
				end
			end
			ARB_OWNED: begin
				// Release costs one idle cycle before the next grant
				if (!req_i[owner_q]) begin
					state_d = ARB_IDLE;
				end
			end
			default: begin
				state_d = ARB_IDLE;
			end
		endcase
	end

	always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ARB_IDLE;
			owner_q <= '0;
		end else begin
			state_q <= state_d;
			owner_q <= owner_d;
		end
	end

	assign owned_o = (state_q == ARB_OWNED);
	assign owner_o = owner_q;

endmodule

`default_nettype wire

/* rtl/tc_initiator_mux.sv */
/*
 * Initiator multiplexer
 * Puts the owning initiator's request on a channel and steers the
 * channel response back to that initiator alone
 */

`timescale 1ns/10ps
`default_nettype none

`include "tc_cfg.svh"

module tc_initiator_mux import tc_pkg::*; (
	input  tc_req_t      init_req_i [`TC_NUM_INIT],
	input  logic         owned_i,
	input  tc_init_idx_t owner_i,
	input  tc_rsp_t      chan_rsp_i,
	output tc_req_t      chan_req_o,
	output tc_rsp_t      init_rsp_o [`TC_NUM_INIT]
);

	tc_req_t owner_req;

	assign owner_req = init_req_i[owner_i];

	// Address, data, sel and we follow the owner even when idle
	always_comb begin
		chan_req_o     = owner_req;
		chan_req_o.cyc = owner_req.cyc & owned_i;
		chan_req_o.stb = owner_req.stb & owned_i;
	end

	// Non-owners see all zeros so the per-initiator OR in the top level
	// only ever picks up one live channel
	always_comb begin
		for (int i = 0; i < `TC_NUM_INIT; i++) begin
			if (owned_i && (owner_i == tc_init_idx_t'(i))) begin
				init_rsp_o[i] = chan_rsp_i;
			end else begin
				init_rsp_o[i] = '0;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/tc_channel.sv */
/*
 * One traffic cop channel
 * Per-initiator address hit, arbiter and initiator multiplexer
 */

`timescale 1ns/10ps
`default_nettype none

`include "tc_cfg.svh"

module tc_channel import tc_pkg::*; #(
	parameter int unsigned           PREFIX_W = 4,
	parameter logic [PREFIX_W-1:0]   PREFIX   = '0
) (
	input  logic    wb_clk_i,
	input  logic    rst_n_i,
	input  tc_req_t init_req_i [`TC_NUM_INIT],
	output tc_rsp_t init_rsp_o [`TC_NUM_INIT],
	output tc_req_t chan_req_o,
	input  tc_rsp_t chan_rsp_i
);

	logic [`TC_NUM_INIT-1:0] req;
	logic                    owned;
	logic                    owner_live;
	tc_init_idx_t            owner;

	// An initiator requests this channel while cyc is high and its
	// address falls under the channel prefix
	always_comb begin
		for (int i = 0; i < `TC_NUM_INIT; i++) begin
			req[i] = init_req_i[i].cyc &&
				(init_req_i[i].adr[`TC_AW-1 -: PREFIX_W] == PREFIX);
		end
	end

	tc_arbiter arb_i (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.req_i    (req),
		.owned_o  (owned),
		.owner_o  (owner)
	);

	// In the release cycle the owner may already point elsewhere,
	// so the targets only see it while it still hits this channel
	assign owner_live = owned & req[owner];

	tc_initiator_mux mux_i (
		.init_req_i (init_req_i),
		.owned_i    (owner_live),
		.owner_i    (owner),
		.chan_rsp_i (chan_rsp_i),
		.chan_req_o (chan_req_o),
		.init_rsp_o (init_rsp_o)
	);

endmodule

`default_nettype wire

/* rtl/tc_target_decoder.sv */
/*
 * Shared channel target decoder
 * Routes the channel request to target 1 to 4 by address and returns
 * the selected target's response
 */

`timescale 1ns/10ps
`default_nettype none

`include "tc_cfg.svh"

module tc_target_decoder import tc_pkg::*; (
	input  tc_req_t chan_req_i,
	output tc_rsp_t chan_rsp_o,
	output tc_req_t tgt_req_o [`TC_NUM_SHARED],
	input  tc_rsp_t tgt_rsp_i [`TC_NUM_SHARED]
);

	localparam int unsigned SEL_W = $clog2(`TC_NUM_SHARED);

	logic [SEL_W-1:0] tgt_sel;

	// Field just below the shared prefix
	assign tgt_sel = chan_req_i.adr[`TC_SHD_SEL_LSB +: SEL_W];

	// Everything fans out, only cyc and stb are steered
	always_comb begin
		for (int i = 0; i < `TC_NUM_SHARED; i++) begin
			tgt_req_o[i] = chan_req_i;
			if (tgt_sel != SEL_W'(i)) begin
				tgt_req_o[i].cyc = 1'b0;
				tgt_req_o[i].stb = 1'b0;
			end
		end
	end

	// Idle channel returns nothing
	always_comb begin
		if (chan_req_i.cyc) begin
			chan_rsp_o = tgt_rsp_i[tgt_sel];
		end else begin
			chan_rsp_o = '0;
		end
	end

endmodule

`default_nettype wire

/* rtl/tc_top.sv */
/*
 * Traffic cop top level
 * Private channel for target 0, shared channel with decoder for
 * targets 1 to 4, and the per-initiator OR of both responses
 */

`timescale 1ns/10ps
`default_nettype none

`include "tc_cfg.svh"

module tc_top import tc_pkg::*; (
	input  logic    wb_clk_i,
	input  logic    rst_n_i,

	// Initiator ports
	input  tc_req_t init_req_i [`TC_NUM_INIT],
	output tc_rsp_t init_rsp_o [`TC_NUM_INIT],

	// Target 0 on its own channel
	output tc_req_t t0_req_o,
	input  tc_rsp_t t0_rsp_i,

	// Targets 1 to 4
	output tc_req_t shd_req_o [`TC_NUM_SHARED],
	input  tc_rsp_t shd_rsp_i [`TC_NUM_SHARED]
);

	tc_rsp_t t0_init_rsp  [`TC_NUM_INIT];
	tc_rsp_t shd_init_rsp [`TC_NUM_INIT];
	tc_req_t shd_chan_req;
	tc_rsp_t shd_chan_rsp;

	// Private channel, target 0
	tc_channel #(
		.PREFIX_W (`TC_T0_PREFIX_W),
		.PREFIX   (`TC_T0_PREFIX)
	) t0_ch (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.init_req_i (init_req_i),
		.init_rsp_o (t0_init_rsp),
		.chan_req_o (t0_req_o),
		.chan_rsp_i (t0_rsp_i)
	);

	// Shared channel, one access at a time across targets 1 to 4
	tc_channel #(
		.PREFIX_W (`TC_SHD_PREFIX_W),
		.PREFIX   (`TC_SHD_PREFIX)
	) shd_ch (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.init_req_i (init_req_i),
		.init_rsp_o (shd_init_rsp),
		.chan_req_o (shd_chan_req),
		.chan_rsp_i (shd_chan_rsp)
	);

	tc_target_decoder shd_dec (
		.chan_req_i (shd_chan_req),
		.chan_rsp_o (shd_chan_rsp),
		.tgt_req_o  (shd_req_o),
		.tgt_rsp_i  (shd_rsp_i)
	);

	// Each channel zeroes non-owners, so a plain OR merges them
	always_comb begin
		for (int i = 0; i < `TC_NUM_INIT; i++) begin
			init_rsp_o[i] = t0_init_rsp[i] | shd_init_rsp[i];
		end
	end

endmodule

`default_nettype wire

/* dv/tc_target_model.sv */
/*
 * Behavioral Wishbone memory target
 * 64-word memory with byte selects, registered ack, err tied low
 */

`timescale 1ns/10ps
`default_nettype none

module tc_target_model import tc_pkg::*; (
	input  logic    wb_clk_i,
	input  logic    rst_n_i,
	input  tc_req_t req_i,
	output tc_rsp_t rsp_o
);

	tc_data_t   mem [64];
	logic [5:0] widx;
	logic       hit;

	assign widx = req_i.adr[7:2];
	// One ack per access, a held request is seen again after the ack cycle
	assign hit  = req_i.cyc & req_i.stb & ~rsp_o.ack;

	// Fill pattern tied to the word index
	initial begin
		for (int i = 0; i < 64; i++) begin
			mem[i] = 32'h5A5A_0000 | i;
		end
	end

	always @(posedge wb_clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rsp_o <= '0;
		end else begin
			rsp_o.ack <= hit;
			rsp_o.err <= 1'b0;
			if (hit) begin
				rsp_o.dat <= mem[widx];
				for (int b = 0; b < 4; b++) begin
					if (req_i.we && req_i.sel[b]) begin
						mem[widx][8*b +: 8] <= req_i.dat[8*b +: 8];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* dv/tb_tc_top.sv */
/*
 * Testbench for the traffic cop top level
 * Clock and reset, case file reader, initiator drivers, bus monitor
 * with a shared channel ownership model, and the closing summary
 */

`timescale 1ns/10ps
`default_nettype none

`include "tc_cfg.svh"

module tb_tc_top import tc_pkg::*; ();

	localparam int NUM_WORDS = 6 * 64;

	logic         clk;
	logic         rst_n;
	tc_req_t      init_req [`TC_NUM_INIT];
	tc_rsp_t      init_rsp [`TC_NUM_INIT];
	tc_req_t      t0_req;
	tc_rsp_t      t0_rsp;
	tc_req_t      shd_req [`TC_NUM_SHARED];
	tc_rsp_t      shd_rsp [`TC_NUM_SHARED];
	logic [31:0]  cases [NUM_WORDS];
	tc_data_t     rnd_data [tc_addr_t];
	int           num_cases;
	int           seed;
	int           n_checks;
	int           n_errors;
	int           cycles;
	int           cycle_limit;
	logic         par_seen;
	logic         m_owned;
	tc_init_idx_t m_owner;

	tc_top dut_i (
		.wb_clk_i   (clk),
		.rst_n_i    (rst_n),
		.init_req_i (init_req),
		.init_rsp_o (init_rsp),
		.t0_req_o   (t0_req),
		.t0_rsp_i   (t0_rsp),
		.shd_req_o  (shd_req),
		.shd_rsp_i  (shd_rsp)
	);

	tc_target_model t0_mem (.wb_clk_i(clk), .rst_n_i(rst_n), .req_i(t0_req), .rsp_o(t0_rsp));

	for (genvar g = 0; g < `TC_NUM_SHARED; g++) begin : g_shd
		tc_target_model shd_mem (
			.wb_clk_i (clk),
			.rst_n_i  (rst_n),
			.req_i    (shd_req[g]),
			.rsp_o    (shd_rsp[g])
		);
	end

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Runs one transaction of case k from falling edge to falling edge
	task automatic run_xfer(input int k, output logic hold);
		int          ini;
		int          waited;
		logic [31:0] op;
		tc_addr_t    adr;
		tc_data_t    wdat;
		tc_data_t    exp;
		logic        unmapped;
		logic        done;
		ini  = cases[k*6+1];
		op   = cases[k*6+2];
		adr  = cases[k*6+3];
		wdat = cases[k*6+4];
		exp  = cases[k*6+5];
		hold = op[1];
		unmapped = (adr[31:28] != 4'h8) && (adr[31:30] != 2'b00);
		if (op[2]) begin
			wdat = $random(seed);
		end
		if (!op[0] && rnd_data.exists(adr)) begin
			exp = rnd_data[adr];
		end
		if (op[3]) begin
			repeat (2) @(negedge clk);
		end
		init_req[ini] = '{cyc: 1'b1, stb: 1'b1, adr: adr, sel: 4'hF, we: op[0], dat: wdat};
		waited = 0;
		done = 1'b0;
		// Unmapped addresses never answer so the wait gives up after 10 cycles
		while (!done && !(unmapped && waited == 10)) begin
			@(posedge clk);
			waited++;
			done = init_rsp[ini].ack | init_rsp[ini].err;
		end
		if (unmapped) begin
			check_value($sformatf("init_rsp_o[%0d].ack unmapped", ini), done, 0);
		end else begin
			check_value($sformatf("init_rsp_o[%0d].err", ini), init_rsp[ini].err, 0);
			if (!op[0]) begin
				check_value($sformatf("init_rsp_o[%0d].dat", ini), init_rsp[ini].dat, exp);
			end else if (op[2]) begin
				rnd_data[adr] = wdat;
			end else begin
				rnd_data.delete(adr);
			end
		end
		@(negedge clk);
		if (!hold) begin
			init_req[ini].cyc = 1'b0;
			init_req[ini].stb = 1'b0;
		end
	endtask

	// Runs this initiator's lines of one group in file order
	task automatic run_initiator(input int ini, input logic [31:0] grp);
		logic hold;
		logic busy;
		hold = 1'b0;
		busy = 1'b0;
		for (int k = 0; k < num_cases; k++) begin
			if (cases[k*6] == grp && cases[k*6+1] == ini) begin
				// A dropped cyc stays low for a clock before the next access
				if (busy && !hold) begin
					@(negedge clk);
				end
				run_xfer(k, hold);
				busy = 1'b1;
			end
		end
	endtask

	// Bus monitor sampled on the rising edge where all outputs are settled
	always @(posedge clk) begin
		logic [`TC_NUM_INIT-1:0] shd_hit;
		logic                    shd_busy;
		if (!rst_n) begin
			m_owned = 1'b0;
		end else begin
			shd_busy = 1'b0;
			for (int j = 0; j < `TC_NUM_SHARED; j++) begin
				if (shd_req[j].cyc) begin
					shd_busy = 1'b1;
					check_value($sformatf("shd_req_o[%0d].adr[31:28]", j),
						shd_req[j].adr[31:28], j);
				end
			end
			if (t0_req.cyc) begin
				check_value("t0_req_o.adr[31:28]", t0_req.adr[31:28], 4'h8);
				par_seen = par_seen | shd_busy;
			end
			for (int i = 0; i < `TC_NUM_INIT; i++) begin
				shd_hit[i] = init_req[i].cyc && (init_req[i].adr[31:30] == 2'b00);
				if (init_rsp[i].ack && shd_hit[i]) begin
					check_value($sformatf("init_rsp_o[%0d].ack shared owner", i),
						m_owned && (m_owner == i), 1);
				end
			end
			// Expected owner for the next cycle
			if (m_owned && !shd_hit[m_owner]) begin
				m_owned = 1'b0;
			end else if (!m_owned) begin
				for (int i = 0; i < `TC_NUM_INIT && !m_owned; i++) begin
					if (shd_hit[i]) begin
						m_owned = 1'b1;
						m_owner = tc_init_idx_t'(i);
					end
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout, the cases did not finish within %0d cycles", cycle_limit);
			$display("Summary: %0d checks, %0d errors", n_checks, n_errors);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		seed = 35;
		n_checks = 0;
		n_errors = 0;
		cycles = 0;
		cycle_limit = 0;
		par_seen = 1'b0;
		m_owned = 1'b0;
		m_owner = '0;
		// Every initiator requests through reset, both channels must still be idle after it
		for (int i = 0; i < `TC_NUM_INIT; i++) begin
			init_req[i]     = '0;
			init_req[i].cyc = 1'b1;
			init_req[i].stb = 1'b1;
			init_req[i].adr = (i % 2 == 0) ? 32'h8000_0000 : 32'h1000_0000;
		end
		$readmemh("dv/tc_cases.txt", cases);
		num_cases = 0;
		while (num_cases < NUM_WORDS / 6 && cases[num_cases*6] !== 32'hFFFF_FFFF) begin
			num_cases++;
		end
		cycle_limit = 20 * num_cases + 100;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("t0_req_o.cyc/stb", {t0_req.cyc, t0_req.stb}, 0);
		for (int j = 0; j < `TC_NUM_SHARED; j++) begin
			check_value($sformatf("shd_req_o[%0d].cyc/stb", j),
				{shd_req[j].cyc, shd_req[j].stb}, 0);
		end
		for (int i = 0; i < `TC_NUM_INIT; i++) begin
			check_value($sformatf("init_rsp_o[%0d].ack/err", i),
				{init_rsp[i].ack, init_rsp[i].err}, 0);
		end
		// Withdrawn before the first grant edge so no access starts
		for (int i = 0; i < `TC_NUM_INIT; i++) begin
			init_req[i] = '0;
		end
		// Lines of one group start together
		for (int k = 0; k < num_cases; k++) begin
			if (k == 0 || cases[k*6] != cases[(k-1)*6]) begin
				@(negedge clk);
				fork
					run_initiator(0, cases[k*6]);
					run_initiator(1, cases[k*6]);
					run_initiator(2, cases[k*6]);
					run_initiator(3, cases[k*6]);
				join
			end
		end
		check_value("t0 and shared cyc in one cycle", par_seen, 1);
		$display("Summary: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/tc_pkg.sv
rtl/tc_arbiter.sv
rtl/tc_initiator_mux.sv
rtl/tc_channel.sv
rtl/tc_target_decoder.sv
rtl/tc_top.sv
dv/tc_target_model.sv
dv/tb_tc_top.sv

/* Bender.yml */
package:
  name: tc_traffic_cop

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/tc_pkg.sv
      - rtl/tc_arbiter.sv
      - rtl/tc_initiator_mux.sv
      - rtl/tc_channel.sv
      - rtl/tc_target_decoder.sv
      - rtl/tc_top.sv
  - target: test
    files:
      - dv/tc_target_model.sv
      - dv/tb_tc_top.sv

/* dv/tc_cases.txt */
// group initiator op address wdata expected_rdata
// op: bit0 write, bit1 keep cyc for the next line, bit2 random wdata, bit3 start 2 cycles late
01 0 1 80000010 11110000 00000000
01 1 1 00000020 22220001 00000000
02 2 1 10000030 33330002 00000000
02 3 5 30000050 00000000 00000000
03 3 1 20000040 44440003 00000000
04 1 0 80000010 00000000 11110000
04 2 0 00000020 00000000 22220001
05 0 0 10000030 00000000 33330002
05 3 0 30000050 00000000 00000000
06 2 0 20000040 00000000 44440003
07 0 1 80000014 AAAA0000 00000000
07 1 1 10000034 BBBB0001 00000000
08 1 1 00000024 CCCC0002 00000000
08 3 1 30000054 DDDD0003 00000000
09 3 0 30000054 00000000 DDDD0003
09 1 0 00000024 00000000 CCCC0002
0A 2 3 20000044 EEEE0004 00000000
0A 2 1 00000028 FFFF0005 00000000
0A 0 8 10000034 00000000 BBBB0001
0B 2 0 20000044 00000000 EEEE0004
0B 0 0 00000028 00000000 FFFF0005
0C 1 0 C0000000 00000000 00000000
FFFFFFFF 0 0 00000000 00000000 00000000
